/* avl/avl_decoder.sv */
`timescale 1ns/1ps
`include "avl_consts.svh"

module avl_decoder (
  input  logic              clk,
  input  logic              rst,
  input  avl_pkg::avl_cmd_t cmd,
  output avl_pkg::avl_rsp_t cmd_rsp,
  output avl_pkg::avl_cmd_t ram_cmd,
  input  avl_pkg::avl_rsp_t ram_rsp,
  output avl_pkg::avl_cmd_t timer_cmd,
  input  avl_pkg::avl_rsp_t timer_rsp
);

  import avl_pkg::*;

  avl_slave_t  sel;
  logic [31:0] ram_ofs;
  logic [31:0] timer_ofs;
  logic        derr_rdv;
  logic        derr_wrv;
  avl_rsp_t    derr_rsp;

  // offsets wrap below the base, so one compare covers each range.
  assign ram_ofs   = cmd.address - `AVL_RAM_BASE;
  assign timer_ofs = cmd.address - `AVL_TIMER_BASE;

  always_comb begin
    if (ram_ofs < `AVL_RAM_BYTES) begin
      sel = slave_ram;
    end else if (timer_ofs < `AVL_TIMER_BYTES) begin
      sel = slave_timer;
    end else begin
      sel = slave_none;
    end
  end

  //////////////////////////////////////////////////
  // command fan-out
  //////////////////////////////////////////////////

  always_comb begin
    ram_cmd         = cmd;
    ram_cmd.read    = cmd.read & (sel == slave_ram);
    ram_cmd.write   = cmd.write & (sel == slave_ram);
    timer_cmd       = cmd;
    timer_cmd.read  = cmd.read & (sel == slave_timer);
    timer_cmd.write = cmd.write & (sel == slave_timer);
  end

  //////////////////////////////////////////////////
  // decode-error responder
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      derr_rdv <= 1'b0;
      derr_wrv <= 1'b0;
    end else begin
      derr_rdv <= cmd.read & (sel == slave_none);
      derr_wrv <= cmd.write & (sel == slave_none);
    end
  end

  always_comb begin
    derr_rsp.readdata           = `AVL_DECERR_DATA;
    derr_rsp.response           = `AVL_RESP_DECODEERROR;
    derr_rsp.waitrequest        = 1'b0;
    derr_rsp.readdatavalid      = derr_rdv;
    derr_rsp.writeresponsevalid = derr_wrv;
  end

  // the master holds the address, so sel is still valid at the response.
  always_comb begin
    case (sel)
      slave_ram:   cmd_rsp = ram_rsp;
      slave_timer: cmd_rsp = timer_rsp;
      default:     cmd_rsp = derr_rsp;
    endcase
  end

endmodule

/* avl/avl_master.sv */
`timescale 1ns/1ps

module avl_master (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  avl_pkg::mem_req_t   req,
  output logic                rsp_ready,
  output avl_pkg::mem_rsp_t   rsp,
  output avl_pkg::avl_cmd_t   cmd,
  input  avl_pkg::avl_rsp_t   cmd_rsp
);

  import avl_pkg::*;

  bridge_state_t state;
  avl_cmd_t      cmd_q;
  logic          is_store;
  logic          done;

  assign is_store = |req.wstrb;

  //////////////////////////////////////////////////
  // state and command registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      state       <= idle;
      cmd_q.read  <= 1'b0;
      cmd_q.write <= 1'b0;
    end else begin
      case (state)
        idle: begin
          // req_valid only counts here.
          if (req_valid) begin
            cmd_q.read  <= ~is_store;
            cmd_q.write <= is_store;
            state       <= is_store ? store : load;
          end
        end
        load, store: begin
          // drop the strobe once the slave has taken it.
          if (!cmd_rsp.waitrequest) begin
            cmd_q.read  <= 1'b0;
            cmd_q.write <= 1'b0;
          end
          if (done) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // address and data only change when a request is taken.
  always_ff @(posedge clk) begin
    if (state == idle && req_valid) begin
      cmd_q.address    <= req.addr;
      cmd_q.writedata  <= req.wdata;
      cmd_q.byteenable <= is_store ? req.wstrb : 4'hf;
    end
  end

  assign cmd = cmd_q;

  //////////////////////////////////////////////////
  // core response
  //////////////////////////////////////////////////

  always_comb begin
    case (state)
      load:    done = cmd_rsp.readdatavalid;
      store:   done = cmd_rsp.writeresponsevalid;
      default: done = 1'b0;
    endcase
  end

  assign rsp_ready = done;

  // any code other than okay is an error.
  always_comb begin
    rsp.rdata = cmd_rsp.readdata;
    rsp.err   = |cmd_rsp.response;
  end

endmodule

/* avl_mem_system.f */
+incdir+common
common/avl_pkg.sv
avl/avl_master.sv
avl/avl_decoder.sv
hw/avl_ram.sv
hw/avl_timer.sv
hw/avl_mem_system.sv
testbench/tb_avl_mem_system.sv

/* common/avl_consts.svh */
`ifndef AVL_CONSTS_SVH
`define AVL_CONSTS_SVH

// on-chip ram, 1024 words from address 0.
`define AVL_RAM_BASE 32'h0000_0000
`define AVL_RAM_WORDS 1024
`define AVL_RAM_AW 10
`define AVL_RAM_BYTES 32'h0000_1000

// register block, 16 byte window.
`define AVL_TIMER_BASE 32'h1000_0000
`define AVL_TIMER_BYTES 32'h0000_0010

// register offsets inside the window.
`define AVL_TIMER_COUNT_OFS 4'h0
`define AVL_TIMER_SCRATCH_OFS 4'h4

// avalon response codes.
`define AVL_RESP_OKAY 2'b00
`define AVL_RESP_DECODEERROR 2'b11

// read data for unmapped addresses.
`define AVL_DECERR_DATA 32'hdead_beef

`endif

/* common/avl_pkg.sv */
package avl_pkg;

  //////////////////////////////////////////////////
  // core memory port
  //////////////////////////////////////////////////

  // wstrb of zero marks a load.
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

  //////////////////////////////////////////////////
  // avalon-mm
  //////////////////////////////////////////////////

  // master to slave.
  typedef struct packed {
    logic [31:0] address;
    logic [3:0]  byteenable;
    logic        read;
    logic        write;
    logic [31:0] writedata;
  } avl_cmd_t;

  // slave to master.
  typedef struct packed {
    logic [31:0] readdata;
    logic [1:0]  response;
    logic        waitrequest;
    logic        readdatavalid;
    logic        writeresponsevalid;
  } avl_rsp_t;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    idle,
    load,
    store
  } bridge_state_t;

  typedef enum logic [1:0] {
    slave_ram,
    slave_timer,
    slave_none
  } avl_slave_t;

endpackage

/* hw/avl_mem_system.sv */
`timescale 1ns/1ps

module avl_mem_system (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  avl_pkg::mem_req_t req,
  output logic              rsp_ready,
  output avl_pkg::mem_rsp_t rsp
);

  import avl_pkg::*;

  avl_cmd_t cmd;
  avl_rsp_t cmd_rsp;
  avl_cmd_t ram_cmd;
  avl_rsp_t ram_rsp;
  avl_cmd_t timer_cmd;
  avl_rsp_t timer_rsp;

  // core port to avalon.
  avl_master u_master (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .cmd       (cmd),
    .cmd_rsp   (cmd_rsp)
  );

  avl_decoder u_decoder (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_rsp   (cmd_rsp),
    .ram_cmd   (ram_cmd),
    .ram_rsp   (ram_rsp),
    .timer_cmd (timer_cmd),
    .timer_rsp (timer_rsp)
  );

  avl_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .cmd     (ram_cmd),
    .cmd_rsp (ram_rsp)
  );

  avl_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .cmd     (timer_cmd),
    .cmd_rsp (timer_rsp)
  );

endmodule

/* hw/avl_ram.sv */
`timescale 1ns/1ps
`include "avl_consts.svh"

module avl_ram (
  input  logic              clk,
  input  logic              rst,
  input  avl_pkg::avl_cmd_t cmd,
  output avl_pkg::avl_rsp_t cmd_rsp
);

  logic [31:0]              mem [`AVL_RAM_WORDS];
  logic [`AVL_RAM_AW-1:0]   idx;
  logic                     active;
  logic                     waited;
  logic                     accept;
  logic                     rdv;
  logic                     wrv;
  logic [31:0]              rdata;

  assign idx    = cmd.address[`AVL_RAM_AW+1:2];
  assign active = cmd.read | cmd.write;

  // first cycle of a command stalls, the second one is taken.
  assign accept = active & waited;

  //////////////////////////////////////////////////
  // wait state and response flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      waited <= 1'b0;
      rdv    <= 1'b0;
      wrv    <= 1'b0;
    end else begin
      waited <= active & ~waited;
      rdv    <= accept & cmd.read;
      wrv    <= accept & cmd.write;
    end
  end

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept && cmd.write) begin
      for (int b = 0; b < 4; b++) begin
        if (cmd.byteenable[b]) begin
          mem[idx][8*b +: 8] <= cmd.writedata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && cmd.read) begin
      rdata <= mem[idx];
    end
  end

  always_comb begin
    cmd_rsp.readdata           = rdata;
    cmd_rsp.response           = `AVL_RESP_OKAY;
    cmd_rsp.waitrequest        = active & ~waited;
    cmd_rsp.readdatavalid      = rdv;
    cmd_rsp.writeresponsevalid = wrv;
  end

endmodule

/* hw/avl_timer.sv */
`timescale 1ns/1ps
`include "avl_consts.svh"

module avl_timer (
  input  logic              clk,
  input  logic              rst,
  input  avl_pkg::avl_cmd_t cmd,
  output avl_pkg::avl_rsp_t cmd_rsp
);

  logic [31:0] count;
  logic [31:0] scratch;
  logic [3:0]  ofs;
  logic        hit_count;
  logic        hit_scratch;
  logic [31:0] rd_mux;
  logic [31:0] rdata;
  logic        rdv;
  logic        wrv;

  assign ofs         = {cmd.address[3:2], 2'b00};
  assign hit_count   = (ofs == `AVL_TIMER_COUNT_OFS);
  assign hit_scratch = (ofs == `AVL_TIMER_SCRATCH_OFS);

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      count   <= '0;
      scratch <= '0;
      rdv     <= 1'b0;
      wrv     <= 1'b0;
    end else begin
      // any write to the counter restarts it.
      if (cmd.write && hit_count) begin
        count <= '0;
      end else begin
        count <= count + 32'd1;
      end
      if (cmd.write && hit_scratch) begin
        for (int b = 0; b < 4; b++) begin
          if (cmd.byteenable[b]) begin
            scratch[8*b +: 8] <= cmd.writedata[8*b +: 8];
          end
        end
      end
      rdv <= cmd.read;
      wrv <= cmd.write;
    end
  end

  // unused offsets read as zero.
  always_comb begin
    if (hit_count) begin
      rd_mux = count;
    end else if (hit_scratch) begin
      rd_mux = scratch;
    end else begin
      rd_mux = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd.read) begin
      rdata <= rd_mux;
    end
  end

  always_comb begin
    cmd_rsp.readdata           = rdata;
    cmd_rsp.response           = `AVL_RESP_OKAY;
    cmd_rsp.waitrequest        = 1'b0;
    cmd_rsp.readdatavalid      = rdv;
    cmd_rsp.writeresponsevalid = wrv;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
set -u

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  -f avl_mem_system.f \
  --top-module tb_avl_mem_system \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

/* testbench/tb_avl_mem_system.sv */
`timescale 1ns/1ps
`include "avl_consts.svh"

module tb_avl_mem_system;

  import avl_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int QUIET_CYCLES = 6;

  // how a row's read data is judged.
  localparam int K_TABLE     = 0;
  localparam int K_MODEL     = 1;
  localparam int K_COUNT_A   = 2;
  localparam int K_COUNT_B   = 3;
  localparam int K_COUNT_CLR = 4;

  logic     clk;
  logic     rst;
  logic     req_valid;
  mem_req_t req;
  logic     rsp_ready;
  mem_rsp_t rsp;

  // one entry per transfer.
  string       t_name[$];
  logic [31:0] t_addr[$];
  logic [31:0] t_wdata[$];
  logic [3:0]  t_wstrb[$];
  logic [31:0] t_rdata[$];
  logic [31:0] t_mask[$];
  logic        t_err[$];
  int          t_kind[$];
  logic        t_poke[$];

  logic [31:0] ref_mem [`AVL_RAM_WORDS];
  logic [31:0] ref_scratch;
  logic [31:0] count_a;
  int          stamp_a;
  int          stamp_clr;
  int          seed = 32'h68c5;
  int          errors = 0;
  int          cycle = 0;
  int          limit = 0;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  avl_mem_system dut_i (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= limit) begin
      $display("timeout, no response within %0d cycles", limit);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // ram sits at address 0.
  function automatic logic in_ram(input logic [31:0] addr);
    return addr < `AVL_RAM_BYTES;
  endfunction

  function automatic logic is_scratch(input logic [31:0] addr);
    return addr == (`AVL_TIMER_BASE | {28'd0, `AVL_TIMER_SCRATCH_OFS});
  endfunction

  task automatic check_val(input string name, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, input logic [31:0] rdata,
                         input logic [31:0] mask, input logic err, input int kind,
                         input logic poke);
    t_name.push_back(name);
    t_addr.push_back(addr);
    t_wdata.push_back(wdata);
    t_wstrb.push_back(wstrb);
    t_rdata.push_back(rdata);
    t_mask.push_back(mask);
    t_err.push_back(err);
    t_kind.push_back(kind);
    t_poke.push_back(poke);
  endtask

  //////////////////////////////////////////////////
  // test table
  //////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] d;
    add_row("ram_word_store", 32'h0, 32'h1234_5678, 4'hf, 32'h0, 32'h0, 1'b0, K_TABLE, 1'b0);
    add_row("ram_word_load", 32'h0, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b1);
    add_row("be_base_store", 32'h40, 32'ha5a5_a5a5, 4'hf, 32'h0, 32'h0, 1'b0, K_TABLE, 1'b0);
    add_row("be_0001_store", 32'h40, 32'h1122_3344, 4'h1, 32'h0, 32'h0, 1'b0, K_TABLE, 1'b0);
    add_row("be_0001_load", 32'h40, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b0);
    add_row("be_0110_store", 32'h40, 32'h5566_7788, 4'h6, 32'h0, 32'h0, 1'b0, K_TABLE, 1'b0);
    add_row("be_0110_load", 32'h40, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b0);
    add_row("be_1000_store", 32'h40, 32'h99aa_bbcc, 4'h8, 32'h0, 32'h0, 1'b0, K_TABLE, 1'b0);
    add_row("be_1000_load", 32'h40, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b0);
    add_row("scratch_store", 32'h1000_0004, 32'hcafe_f00d, 4'hf, 32'h0, 32'h0, 1'b0, K_TABLE,
            1'b0);
    add_row("scratch_be_store", 32'h1000_0004, 32'h0102_0304, 4'h5, 32'h0, 32'h0, 1'b0,
            K_TABLE, 1'b0);
    add_row("scratch_load", 32'h1000_0004, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b1);
    add_row("count_clear", 32'h1000_0000, '1, 4'hf, 32'h0, 32'h0, 1'b0, K_COUNT_CLR, 1'b0);
    add_row("count_load_a", 32'h1000_0000, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_COUNT_A, 1'b0);
    add_row("count_load_b", 32'h1000_0000, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_COUNT_B, 1'b0);
    add_row("decerr_load", 32'h2000_0000, 32'h0, 4'h0, `AVL_DECERR_DATA, '1, 1'b1, K_TABLE,
            1'b0);
    add_row("decerr_store", 32'h2000_0000, '1, 4'hf, 32'h0, 32'h0, 1'b1, K_TABLE, 1'b0);
    add_row("ram_word0_check", 32'h0, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b0);
    for (int i = 0; i < 16; i++) begin
      a = $random(seed) & 32'h0000_0ffc;
      d = $random(seed);
      add_row($sformatf("rand%0d_store", i), a, d, 4'hf, 32'h0, 32'h0, 1'b0, K_TABLE, 1'b0);
      add_row($sformatf("rand%0d_load", i), a, 32'h0, 4'h0, 32'h0, '1, 1'b0, K_MODEL, 1'b0);
    end
  endtask

  task automatic apply_row(input int r);
    int          lat;
    logic [31:0] exp;
    logic [31:0] a;
    a = t_addr[r];
    @(posedge clk);
    req_valid <= 1'b1;
    req.addr  <= a;
    req.wdata <= t_wdata[r];
    req.wstrb <= t_wstrb[r];
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      if (lat == 1 && t_poke[r]) begin
        // a strobe during a busy transfer.
        req_valid <= 1'b1;
        req.addr  <= 32'h0000_0ffc;
        req.wstrb <= 4'h0;
      end else begin
        req_valid <= 1'b0;
      end
    end while (!rsp_ready);
    check_val(t_name[r], "latency", in_ram(a) ? 32'd4 : 32'd3, lat);
    check_val(t_name[r], "err", {31'd0, t_err[r]}, {31'd0, rsp.err});
    case (t_kind[r])
      K_MODEL: begin
        exp = in_ram(a) ? ref_mem[a[11:2]] : ref_scratch;
        check_val(t_name[r], "rdata", exp, rsp.rdata);
      end
      K_COUNT_CLR: begin
        stamp_clr = cycle;
      end
      K_COUNT_A: begin
        // zero while the clear is answered, one less than the spacing when the load is.
        check_val(t_name[r], "count after clear", cycle - stamp_clr - 1, rsp.rdata);
        count_a = rsp.rdata;
        stamp_a = cycle;
      end
      K_COUNT_B: begin
        check_val(t_name[r], "count step", cycle - stamp_a, rsp.rdata - count_a);
      end
      default: begin
        if (t_mask[r] != 32'd0) begin
          check_val(t_name[r], "rdata", t_rdata[r] & t_mask[r], rsp.rdata & t_mask[r]);
        end
      end
    endcase
    if (t_wstrb[r] != 4'h0 && in_ram(a)) begin
      ref_mem[a[11:2]] = merge_bytes(ref_mem[a[11:2]], t_wdata[r], t_wstrb[r]);
    end else if (t_wstrb[r] != 4'h0 && is_scratch(a)) begin
      ref_scratch = merge_bytes(ref_scratch, t_wdata[r], t_wstrb[r]);
    end
    if (t_poke[r]) begin
      repeat (QUIET_CYCLES) begin
        @(posedge clk);
        assert (!rsp_ready) else begin
          errors++;
          $display("extra response after a strobe sent while busy in %s", t_name[r]);
        end
      end
    end
  endtask

  initial begin
    rst         = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    ref_scratch = '0;
    build_table();
    limit = t_name.size() * 10 + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b1;
    for (int r = 0; r < t_name.size(); r++) begin
      apply_row(r);
    end
    repeat (2) @(posedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
